/* design/approx_pkg.sv */
package approx_pkg;

    // Error-rate input width, shared by the adder, both units and the top
    localparam int ER_W = 8;

    // Unit selector on the command port and on the result bus
    typedef enum logic
    {
        OP_DIV = 1'b0,  // Restoring divider
        OP_MUL = 1'b1   // Shift-add multiplier
    } op_e;

    // Unit sequencing, same for divider and multiplier
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0, // Waiting for start
        ST_RUN  = 2'd1, // One step per cycle
        ST_HOLD = 2'd2  // Result parked until granted
    } unit_state_e;

    // A run lasts WIDTH steps
    // The unit counters use this width, at least 1 bit
    function automatic int step_cnt_w(input int width);
        if (width > 1)
            return $clog2(width);
        else
            return 1;
    endfunction

endpackage

/* design/approx_adder.sv */
`timescale 1ns/1ps

// Lower-part OR adder
// Low k bits carry-free OR, upper bits exact
module approx_adder
    import approx_pkg::*;
#(
    parameter int WIDTH   = 32,
    parameter int APX_LEN = 8
)
(
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    input  logic [ER_W-1:0]  er,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [ER_W-1:0]  k;          // Approximate width after clamp
    logic [WIDTH-1:0] low_mask;   // Ones over the OR part
    logic [WIDTH-1:0] top_bit;    // One-hot at position k-1
    logic             carry_k;    // Carry into the exact part
    logic [WIDTH:0]   upper_sum;  // Exact part plus carry-out

    // Clamp error rate to the largest allowed approximate width
    always_comb
    begin
        if (int'(er) > APX_LEN)
            k = ER_W'(APX_LEN);
        else
            k = er;
    end

    // k == WIDTH wraps to all ones, which is still the right mask
    assign low_mask = (WIDTH'(1) << k) - WIDTH'(1);
    assign top_bit  = low_mask ^ (low_mask >> 1);   // Zero when k is 0

    // Carry guessed from the top approximate bit pair
    // cin only matters without an approximate part
    assign carry_k = (k == '0) ? cin : |(a & b & top_bit);

    // Upper operands with the low part cleared, carry injected at bit k
    assign upper_sum = {1'b0, a & ~low_mask}
                     + {1'b0, b & ~low_mask}
                     + ({{WIDTH{1'b0}}, carry_k} << k);

    assign sum  = (upper_sum[WIDTH-1:0] & ~low_mask) | ((a | b) & low_mask);
    assign cout = upper_sum[WIDTH];

endmodule

/* design/approx_divider.sv */
`timescale 1ns/1ps

// Restoring divider, one quotient bit per cycle
// Trial subtract goes through the approximate adder
module approx_divider
    import approx_pkg::*;
#(
    parameter int WIDTH   = 32,
    parameter int APX_LEN = 8
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    input  logic [ER_W-1:0]  er,
    output logic             busy,
    output logic             req,
    input  logic             grant,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    localparam int CNT_W = step_cnt_w(WIDTH);

    unit_state_e      state;
    logic [CNT_W-1:0] cnt;        // Steps done in this run
    logic [WIDTH-1:0] quo_q;      // Dividend bits out, quotient bits in
    logic [WIDTH-1:0] rem_q;      // Partial remainder
    logic [WIDTH-1:0] dvsr_q;
    logic [ER_W-1:0]  er_q;       // Error rate fixed for the run
    logic             div_zero;   // Result preloaded, steps skipped
    logic [WIDTH-1:0] shifted;    // Remainder with next dividend bit
    logic [WIDTH-1:0] diff;
    logic             cout;
    logic             take;       // Subtract this step

    assign shifted = {rem_q[WIDTH-2:0], quo_q[WIDTH-1]};

    // shifted + ~divisor + 1, i.e. shifted - divisor
    approx_adder #(
        .WIDTH   (WIDTH),
        .APX_LEN (APX_LEN)
    ) sub_adder (
        .a    (shifted),
        .b    (~dvsr_q),
        .cin  (1'b1),
        .er   (er_q),
        .sum  (diff),
        .cout (cout)
    );

    // Carry-out of the comparison widened by one bit
    // A bit shifted out of the remainder means shifted exceeds the divisor
    assign take = cout | rem_q[WIDTH-1];

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH - 1))
                        state <= ST_HOLD;   // Last step this edge
                end
                ST_HOLD:
                begin
                    if (grant)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            dvsr_q   <= divisor;
            er_q     <= er;
            div_zero <= (divisor == '0);
            quo_q    <= (divisor == '0) ? '1 : dividend;         // All ones on zero divisor
            rem_q    <= (divisor == '0) ? dividend : '0;
        end
        else if (state == ST_RUN && !div_zero)
        begin
            rem_q <= take ? diff : shifted;     // Restore by keeping shifted
            quo_q <= {quo_q[WIDTH-2:0], take};
        end
    end

    assign busy      = (state != ST_IDLE);
    assign req       = (state == ST_HOLD);
    assign quotient  = quo_q;
    assign remainder = rem_q;

    // Top level must gate starts with busy
    a_start_idle: assert property (@(posedge CLK) disable iff (!rst_n)
        start |-> state == ST_IDLE)
        else $error("divider start while not idle");

endmodule

/* design/approx_multiplier.sv */
`timescale 1ns/1ps

// Shift-add multiplier, one multiplier bit per cycle
module approx_multiplier
    import approx_pkg::*;
#(
    parameter int WIDTH   = 32,
    parameter int APX_LEN = 8
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             start,
    input  logic [WIDTH-1:0] multiplicand,
    input  logic [WIDTH-1:0] multiplier,
    input  logic [ER_W-1:0]  er,
    output logic             busy,
    output logic             req,
    input  logic             grant,
    output logic [WIDTH-1:0] product_hi,
    output logic [WIDTH-1:0] product_lo
);

    localparam int CNT_W = step_cnt_w(WIDTH);

    unit_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [WIDTH-1:0] mcand_q;
    logic [WIDTH-1:0] acc_hi;     // Partial product
    logic [WIDTH-1:0] acc_lo;     // Multiplier bits out, product bits in
    logic [ER_W-1:0]  er_q;
    logic [WIDTH-1:0] addend;     // Multiplicand or zero
    logic [WIDTH-1:0] sum;
    logic             cout;

    // Adding zero through the LOA is exact, so one adder path suffices
    assign addend = acc_lo[0] ? mcand_q : '0;

    approx_adder #(
        .WIDTH   (WIDTH),
        .APX_LEN (APX_LEN)
    ) acc_adder (
        .a    (acc_hi),
        .b    (addend),
        .cin  (1'b0),
        .er   (er_q),
        .sum  (sum),
        .cout (cout)
    );

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH - 1))
                        state <= ST_HOLD;
                end
                ST_HOLD:
                begin
                    if (grant)
                        state <= ST_IDLE;   // Freed on the grant edge
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            mcand_q <= multiplicand;
            er_q    <= er;
            acc_hi  <= '0;
            acc_lo  <= multiplier;
        end
        else if (state == ST_RUN)
        begin
            // {cout, sum, acc_lo} shifted right by one
            acc_hi <= {cout, sum[WIDTH-1:1]};
            acc_lo <= {sum[0], acc_lo[WIDTH-1:1]};
        end
    end

    assign busy       = (state != ST_IDLE);
    assign req        = (state == ST_HOLD);
    assign product_hi = acc_hi;
    assign product_lo = acc_lo;

    // Result stays parked until the arbiter takes it
    a_req_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        req && !grant |=> req)
        else $error("multiplier dropped req without grant");

endmodule

/* design/result_arbiter.sv */
`timescale 1ns/1ps

// Round-robin owner of the shared result bus
module result_arbiter
    import approx_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             div_req,
    input  logic             mul_req,
    input  logic [WIDTH-1:0] div_hi,
    input  logic [WIDTH-1:0] div_lo,
    input  logic [WIDTH-1:0] mul_hi,
    input  logic [WIDTH-1:0] mul_lo,
    output logic             div_grant,
    output logic             mul_grant,
    output logic             result_valid,
    output op_e              result_op,
    output logic [WIDTH-1:0] result_hi,
    output logic [WIDTH-1:0] result_lo
);

    op_e rr_ptr;    // Unit favoured on a tie

    // Grant in the request cycle, tie broken by the pointer
    assign div_grant = div_req && (!mul_req || rr_ptr == OP_DIV);
    assign mul_grant = mul_req && (!div_req || rr_ptr == OP_MUL);

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            rr_ptr       <= OP_DIV;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= div_grant || mul_grant;     // One-cycle pulse
            if (div_grant)
                rr_ptr <= OP_MUL;   // Other unit next
            else if (mul_grant)
                rr_ptr <= OP_DIV;
        end
    end

    // Result bus payload
    always_ff @(posedge CLK)
    begin
        if (div_grant)
        begin
            result_op <= OP_DIV;
            result_hi <= div_hi;
            result_lo <= div_lo;
        end
        else if (mul_grant)
        begin
            result_op <= OP_MUL;
            result_hi <= mul_hi;
            result_lo <= mul_lo;
        end
    end

    a_onehot_grant: assert property (@(posedge CLK) disable iff (!rst_n)
        !(div_grant && mul_grant))
        else $error("both units granted");

    a_grant_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
        (div_grant |-> div_req) and (mul_grant |-> mul_req))
        else $error("grant without request");

endmodule

/* design/approx_arith_top.sv */
`timescale 1ns/1ps

// Approximate arithmetic accelerator
// Command strobe in, arbitrated result bus out
module approx_arith_top
    import approx_pkg::*;
#(
    parameter int WIDTH   = 32,
    parameter int APX_LEN = 8
)
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  op_e              cmd_op,
    input  logic [WIDTH-1:0] cmd_a,
    input  logic [WIDTH-1:0] cmd_b,
    input  logic [ER_W-1:0]  cmd_er,
    output logic             div_busy,
    output logic             mul_busy,
    output logic             result_valid,
    output op_e              result_op,
    output logic [WIDTH-1:0] result_hi,
    output logic [WIDTH-1:0] result_lo
);

    logic             div_start;
    logic             mul_start;
    logic             div_req;
    logic             mul_req;
    logic             div_grant;
    logic             mul_grant;
    logic [WIDTH-1:0] div_quo;
    logic [WIDTH-1:0] div_rem;
    logic [WIDTH-1:0] mul_hi;
    logic [WIDTH-1:0] mul_lo;

    // Commands to a busy unit are dropped
    assign div_start = cmd_valid && (cmd_op == OP_DIV) && !div_busy;
    assign mul_start = cmd_valid && (cmd_op == OP_MUL) && !mul_busy;

    approx_divider #(
        .WIDTH   (WIDTH),
        .APX_LEN (APX_LEN)
    ) approx_divider_inst (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .start     (div_start),
        .dividend  (cmd_a),
        .divisor   (cmd_b),
        .er        (cmd_er),
        .busy      (div_busy),
        .req       (div_req),
        .grant     (div_grant),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

    approx_multiplier #(
        .WIDTH   (WIDTH),
        .APX_LEN (APX_LEN)
    ) approx_multiplier_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .start        (mul_start),
        .multiplicand (cmd_a),
        .multiplier   (cmd_b),
        .er           (cmd_er),
        .busy         (mul_busy),
        .req          (mul_req),
        .grant        (mul_grant),
        .product_hi   (mul_hi),
        .product_lo   (mul_lo)
    );

    // Remainder on hi, quotient on lo
    result_arbiter #(
        .WIDTH (WIDTH)
    ) result_arbiter_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .div_req      (div_req),
        .mul_req      (mul_req),
        .div_hi       (div_rem),
        .div_lo       (div_quo),
        .mul_hi       (mul_hi),
        .mul_lo       (mul_lo),
        .div_grant    (div_grant),
        .mul_grant    (mul_grant),
        .result_valid (result_valid),
        .result_op    (result_op),
        .result_hi    (result_hi),
        .result_lo    (result_lo)
    );

endmodule

/* tb/approx_ref_model.svh */
`ifndef APPROX_REF_MODEL_SVH
`define APPROX_REF_MODEL_SVH

// LOA reference, result is {cout, sum}
function automatic logic [WIDTH:0] ref_add(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                           input logic cin, input logic [ER_W-1:0] er);
    int               k;
    logic [WIDTH-1:0] mask;
    logic [WIDTH:0]   upper;
    k = (int'(er) > APX_LEN) ? APX_LEN : int'(er);    // Clamp
    if (k == 0)
        return {1'b0, a} + {1'b0, b} + cin;           // Plain exact add
    mask  = ~({WIDTH{1'b1}} << k);                    // Low k bits
    // Upper part exact, carry guessed from bit k-1 pair
    upper = {1'b0, a >> k} + {1'b0, b >> k} + (a[k-1] & b[k-1]);
    return (upper << k) | {1'b0, (a | b) & mask};
endfunction

// Restoring division, result is {remainder, quotient}
function automatic logic [2*WIDTH-1:0] ref_div(input logic [WIDTH-1:0] a,
                                               input logic [WIDTH-1:0] b,
                                               input logic [ER_W-1:0] er);
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] shifted;
    logic [WIDTH:0]   trial;
    logic             take;
    if (b == '0)
        return {a, {WIDTH{1'b1}}};
    rem = '0;
    quo = a;    // Dividend bits leave at the top
    for (int i = 0; i < WIDTH; i++)
    begin
        shifted = {rem[WIDTH-2:0], quo[WIDTH-1]};
        trial   = ref_add(shifted, ~b, 1'b1, er);     // shifted - b
        take    = trial[WIDTH] | rem[WIDTH-1];        // Bit pushed out means larger than b
        rem     = take ? trial[WIDTH-1:0] : shifted;
        quo     = {quo[WIDTH-2:0], take};
    end
    return {rem, quo};
endfunction

// Shift-add product, result is {hi, lo}
function automatic logic [2*WIDTH-1:0] ref_mul(input logic [WIDTH-1:0] a,
                                               input logic [WIDTH-1:0] b,
                                               input logic [ER_W-1:0] er);
    logic [WIDTH-1:0] hi;
    logic [WIDTH-1:0] lo;
    logic [WIDTH:0]   step;
    hi = '0;
    lo = b;
    for (int i = 0; i < WIDTH; i++)
    begin
        step = ref_add(hi, lo[0] ? a : '0, 1'b0, er);
        {hi, lo} = {step, lo[WIDTH-1:1]};   // Carry-out enters at the top
    end
    return {hi, lo};
endfunction

`endif

/* tb/approx_arith_tb.sv */
`timescale 1ns/1ps

module approx_arith_tb
    import approx_pkg::*;
();

    localparam int WIDTH       = 32;
    localparam int APX_LEN     = 8;
    localparam int N_CMDS      = 44;                               // All commands sent
    localparam int WATCHDOG_NS = N_CMDS * (2 * WIDTH + 10) * 40;

    logic             CLK;
    logic             rst_n;
    logic             cmd_valid;
    op_e              cmd_op;
    logic [WIDTH-1:0] cmd_a;
    logic [WIDTH-1:0] cmd_b;
    logic [ER_W-1:0]  cmd_er;
    logic             div_busy;
    logic             mul_busy;
    logic             result_valid;
    op_e              result_op;
    logic [WIDTH-1:0] result_hi;
    logic [WIDTH-1:0] result_lo;

    logic [2*WIDTH-1:0] exp_div[$];     // {hi, lo} per accepted divide
    logic [2*WIDTH-1:0] exp_mul[$];
    string              name_div[$];    // Owning test of each entry
    string              name_mul[$];
    op_e                order_log[$];   // Arrival order on the result bus
    string              cur_test = "";
    int                 seed = 47;
    int                 check_count;
    int                 error_count;
    int                 accepted_count;
    int                 dropped_count;
    int                 result_count;
    int                 test_checks;
    int                 test_errors;

    `include "approx_ref_model.svh"

    approx_arith_top #(
        .WIDTH   (WIDTH),
        .APX_LEN (APX_LEN)
    ) approx_arith_top_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_a        (cmd_a),
        .cmd_b        (cmd_b),
        .cmd_er       (cmd_er),
        .div_busy     (div_busy),
        .mul_busy     (mul_busy),
        .result_valid (result_valid),
        .result_op    (result_op),
        .result_hi    (result_hi),
        .result_lo    (result_lo)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;     // 40 ns period
    end

    // Exact arithmetic for er 0 and the LOA model otherwise
    function automatic logic [2*WIDTH-1:0] expected_result(input op_e op,
            input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b, input logic [ER_W-1:0] er);
        logic [2*WIDTH-1:0] wide_a;
        logic [2*WIDTH-1:0] wide_b;
        wide_a = {{WIDTH{1'b0}}, a};
        wide_b = {{WIDTH{1'b0}}, b};
        if (op == OP_DIV && b == '0)
            return {a, {WIDTH{1'b1}}};      // Zero divisor convention
        if (er != '0)
            return (op == OP_DIV) ? ref_div(a, b, er) : ref_mul(a, b, er);
        if (op == OP_MUL)
            return wide_a * wide_b;
        return {a % b, a / b};
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic send_cmd(input op_e op, input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                            input logic [ER_W-1:0] er, input bit wait_idle);
        bit unit_busy;
        unit_busy = (op == OP_DIV) ? div_busy : mul_busy;
        while (wait_idle && unit_busy)
        begin
            @(posedge CLK);
            #2;
            unit_busy = (op == OP_DIV) ? div_busy : mul_busy;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_a     = a;
        cmd_b     = b;
        cmd_er    = er;
        if (unit_busy)
            dropped_count++;    // DUT must ignore it
        else if (op == OP_DIV)
        begin
            exp_div.push_back(expected_result(op, a, b, er));
            name_div.push_back(cur_test);
            accepted_count++;
        end
        else
        begin
            exp_mul.push_back(expected_result(op, a, b, er));
            name_mul.push_back(cur_test);
            accepted_count++;
        end
        @(posedge CLK);
        #2;
        cmd_valid = 1'b0;
    endtask

    // Until both units are back in idle
    task automatic wait_drain();
        while (div_busy || mul_busy)
        begin
            @(posedge CLK);
            #2;
        end
        @(posedge CLK);     // Result pulse follows the grant edge
        #2;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        wait_drain();
        $display("%-12s done: %0d checks, %0d errors", cur_test,
                 check_count - test_checks, error_count - test_errors);
    endtask

    // Result bus sampled mid-cycle
    always @(negedge CLK)
    begin : result_check
        logic [2*WIDTH-1:0] exp_word;
        string              exp_name;
        bit                 have_exp;
        if (rst_n && result_valid)
        begin
            result_count++;
            order_log.push_back(result_op);
            have_exp = (result_op == OP_DIV) ? (exp_div.size() != 0) : (exp_mul.size() != 0);
            check_count++;
            assert (have_exp)
            else
            begin
                $display("ERROR: %s result arrived with no command outstanding in test %s",
                         result_op.name(), cur_test);
                error_count++;
            end
            if (have_exp)
            begin
                exp_word = (result_op == OP_DIV) ? exp_div.pop_front() : exp_mul.pop_front();
                exp_name = (result_op == OP_DIV) ? name_div.pop_front() : name_mul.pop_front();
                check_count++;
                assert ({result_hi, result_lo} == exp_word)
                else
                begin
                    $display("MISMATCH %s %s: expected %h_%h, actual %h_%h", exp_name,
                             result_op.name(), exp_word[2*WIDTH-1:WIDTH], exp_word[WIDTH-1:0],
                             result_hi, result_lo);
                    error_count++;
                end
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns, test %s still waiting on results",
                 WATCHDOG_NS, cur_test);
        $display("Test failed");
        $finish;
    end

    initial
    begin : stimulus
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [ER_W-1:0]  er_list[4];
        op_e              pair_order[6];
        er_list    = '{8'd1, 8'd4, 8'd8, 8'd200};   // 200 exercises the clamp
        pair_order = '{OP_DIV, OP_MUL, OP_MUL, OP_DIV, OP_DIV, OP_MUL};
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_DIV;
        cmd_a     = '0;
        cmd_b     = '0;
        cmd_er    = '0;
        repeat (8) @(posedge CLK);
        #2;
        rst_n = 1'b1;

        // One command port puts each pair on adjacent cycles
        begin_test("rr_pairs");
        order_log.delete();
        for (int p = 0; p < 3; p++)
        begin
            send_cmd(pair_order[2*p], $random(seed), $random(seed), '0, 1'b1);
            send_cmd(pair_order[2*p+1], $random(seed), $random(seed), 8'd4, 1'b1);
            wait_drain();
        end
        check_count++;
        assert (order_log.size() == 6)
        else
        begin
            $display("ERROR: pair test saw %0d results instead of 6", order_log.size());
            error_count++;
        end
        foreach (pair_order[i])
        begin
            if (i < order_log.size())
            begin
                check_count++;
                assert (order_log[i] == pair_order[i])
                else
                begin
                    $display("MISMATCH rr_pairs slot %0d: expected %s, actual %s", i,
                             pair_order[i].name(), order_log[i].name());
                    error_count++;
                end
            end
        end
        finish_test();

        begin_test("exact_div");
        repeat (8)
        begin
            a = $random(seed);
            b = $unsigned($random(seed)) >> ($unsigned($random(seed)) % WIDTH);  // Varied size
            send_cmd(OP_DIV, a, b, '0, 1'b1);
        end
        finish_test();

        begin_test("exact_mul");
        repeat (8)
            send_cmd(OP_MUL, $random(seed), $random(seed), '0, 1'b1);
        finish_test();

        begin_test("approx_er");
        foreach (er_list[i])
        begin
            repeat (2)
            begin
                a = $random(seed);
                b = $unsigned($random(seed)) >> ($unsigned($random(seed)) % 24);
                send_cmd(OP_DIV, a, b, er_list[i], 1'b1);
                send_cmd(OP_MUL, $random(seed), $random(seed), er_list[i], 1'b1);
            end
        end
        finish_test();

        begin_test("div_zero");
        send_cmd(OP_DIV, $random(seed), '0, '0, 1'b1);
        send_cmd(OP_DIV, $random(seed), '0, 8'd200, 1'b1);
        finish_test();

        // Second command of each unit hits a busy unit
        begin_test("busy_drop");
        send_cmd(OP_DIV, $random(seed), 32'd7, '0, 1'b1);
        send_cmd(OP_DIV, $random(seed), 32'd3, '0, 1'b0);
        send_cmd(OP_MUL, $random(seed), $random(seed), '0, 1'b1);
        send_cmd(OP_MUL, $random(seed), $random(seed), '0, 1'b0);
        check_count++;
        assert (dropped_count == 2)
        else
        begin
            $display("ERROR: busy level was low for a command sent right after acceptance");
            error_count++;
        end
        finish_test();

        check_count += 2;
        assert (exp_div.size() == 0 && exp_mul.size() == 0)
        else
        begin
            $display("ERROR: %0d results never came back", exp_div.size() + exp_mul.size());
            error_count++;
        end
        assert (result_count == accepted_count)
        else
        begin
            $display("MISMATCH final_count: expected %0d, actual %0d", accepted_count,
                     result_count);
            error_count++;
        end
        $display("Checks %0d, errors %0d, accepted %0d, dropped %0d, results %0d",
                 check_count, error_count, accepted_count, dropped_count, result_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+tb
design/approx_pkg.sv
design/approx_adder.sv
design/approx_divider.sv
design/approx_multiplier.sv
design/result_arbiter.sv
design/approx_arith_top.sv
tb/approx_arith_tb.sv
